//--- build.f
decodePkg.sv
immGen.sv
ctrlDecode.sv
fwdUnit.sv
idPipeReg.sv
idStage.sv
tbClock.sv
tbChecker.sv
tb_idStage.sv

//--- ctrlDecode.sv
`timescale 1ns/1ps

module ctrlDecode import decodePkg::*; (
  input  logic [XLEN-1:0] instr,
  output aluOpT           aluOp,
  output srcAT            srcA,
  output srcBT            srcB,
  output wbSelT           wbSel,
  output logic            regWrite,
  output logic            memRead,
  output logic            memWrite,
  output memSizeT         memSize,
  output logic            loadUnsigned,
  output pcSelT           pcSel,
  output logic            usesRs1,
  output logic            usesRs2
);

  opcodeT     opcode;
  logic [2:0] funct3;
  logic       altFunct;  // funct7 bit 5

  assign opcode   = opcodeT'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign altFunct = instr[30];

  // SUB exists only in the register form, SRA in both
  function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt,
                                          input logic isReg);
    aluOpT op;
    case (f3)
      f3AddSub: op = (alt && isReg) ? aluSub : aluAdd;
      f3Sll:    op = aluSll;
      f3Slt:    op = aluSlt;
      f3Sltu:   op = aluSltu;
      f3Xor:    op = aluXor;
      f3SrlSra: op = alt ? aluSra : aluSrl;
      f3Or:     op = aluOr;
      f3And:    op = aluAnd;
    endcase
    return op;
  endfunction

  always_comb begin
    // no-op unless an opcode below says otherwise
    aluOp        = aluAdd;
    srcA         = srcARs1;
    srcB         = srcBRs2;
    wbSel        = wbAlu;
    regWrite     = 1'b0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    memSize      = memWord;
    loadUnsigned = 1'b0;
    pcSel        = pcSeq;
    usesRs1      = 1'b0;
    usesRs2      = 1'b0;

    case (opcode)
      opOp, opOpImm: begin
        aluOp    = aluFromFunct3(funct3, altFunct, opcode == opOp);
        srcB     = (opcode == opOp) ? srcBRs2 : srcBImm;
        regWrite = 1'b1;
        usesRs1  = 1'b1;
        usesRs2  = (opcode == opOp);
      end
      opLoad: begin
        srcB     = srcBImm;  // address is rs1 + imm
        wbSel    = wbMem;
        regWrite = 1'b1;
        memRead  = 1'b1;
        usesRs1  = 1'b1;
        case (funct3)
          f3Lb, f3Lbu: memSize = memByte;
          f3Lh, f3Lhu: memSize = memHalf;
          default:     memSize = memWord;
        endcase
        loadUnsigned = (funct3 == f3Lbu) || (funct3 == f3Lhu);
      end
      opStore: begin
        srcB     = srcBImm;
        memWrite = 1'b1;
        usesRs1  = 1'b1;
        usesRs2  = 1'b1;  // store data
        case (funct3)
          f3Sb:    memSize = memByte;
          f3Sh:    memSize = memHalf;
          default: memSize = memWord;
        endcase
      end
      opBranch: begin
        pcSel   = pcBranch;
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
        case (funct3)
          f3Bne:   aluOp = aluNe;
          f3Blt:   aluOp = aluSlt;
          f3Bge:   aluOp = aluGe;
          f3Bltu:  aluOp = aluSltu;
          f3Bgeu:  aluOp = aluGeu;
          default: aluOp = aluEq;  // BEQ and reserved codes
        endcase
      end
      opJal, opJalr: begin
        srcA     = srcAPc;  // link value pc + 4
        srcB     = srcBFour;
        wbSel    = wbPcPlus4;
        regWrite = 1'b1;
        pcSel    = (opcode == opJal) ? pcJal : pcJalr;
        usesRs1  = (opcode == opJalr);
      end
      opLui: begin
        srcA     = srcAZero;
        srcB     = srcBImm;
        regWrite = 1'b1;
      end
      opAuipc: begin
        srcA     = srcAPc;
        srcB     = srcBImm;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- decodePkg.sv
package decodePkg;

  //--------------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------------
  localparam int XLEN       = 32;  // data and pc width
  localparam int REG_ADDR_W = 5;

  //--------------------------------------------------------------------------
  // opcodes and funct3 codes
  //--------------------------------------------------------------------------
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opOp     = 7'b0110011,
    opOpImm  = 7'b0010011,
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011
  } opcodeT;

  // alu group shared by OP and OP-IMM
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  localparam logic [2:0] f3Lb  = 3'b000;  // loads
  localparam logic [2:0] f3Lh  = 3'b001;
  localparam logic [2:0] f3Lw  = 3'b010;
  localparam logic [2:0] f3Lbu = 3'b100;
  localparam logic [2:0] f3Lhu = 3'b101;

  localparam logic [2:0] f3Sb = 3'b000;  // stores
  localparam logic [2:0] f3Sh = 3'b001;
  localparam logic [2:0] f3Sw = 3'b010;

  localparam logic [2:0] f3Beq  = 3'b000;  // branches
  localparam logic [2:0] f3Bne  = 3'b001;
  localparam logic [2:0] f3Blt  = 3'b100;
  localparam logic [2:0] f3Bge  = 3'b101;
  localparam logic [2:0] f3Bltu = 3'b110;
  localparam logic [2:0] f3Bgeu = 3'b111;

  //--------------------------------------------------------------------------
  // control fields
  //--------------------------------------------------------------------------
  typedef enum logic [3:0] {
    aluAnd  = 4'b0000,
    aluOr   = 4'b0001,
    aluXor  = 4'b0010,
    aluAdd  = 4'b0011,
    aluSub  = 4'b0100,
    aluSlt  = 4'b0101,  // also BLT
    aluSltu = 4'b0110,  // also BLTU
    aluSll  = 4'b0111,
    aluSrl  = 4'b1000,
    aluSra  = 4'b1001,
    aluGe   = 4'b1011,
    aluGeu  = 4'b1100,
    aluNe   = 4'b1101,
    aluEq   = 4'b1110
  } aluOpT;

  typedef enum logic [1:0] {srcARs1, srcAPc, srcAZero} srcAT;
  typedef enum logic [1:0] {srcBRs2, srcBImm, srcBFour} srcBT;
  typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSelT;
  typedef enum logic [1:0] {memByte, memHalf, memWord} memSizeT;
  typedef enum logic [1:0] {pcSeq, pcBranch, pcJal, pcJalr} pcSelT;

  // distance counted in pipeline slots ahead of the decoding instruction
  typedef enum logic [1:0] {fwdNone, fwdDist1, fwdDist2, fwdDist3} fwdSelT;

endpackage

//--- fwdUnit.sv
`timescale 1ns/1ps

module fwdUnit import decodePkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  advance,  // stage moves this cycle
  input  logic                  accept,   // new instruction taken this cycle
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic                  usesRs1,
  input  logic                  usesRs2,
  input  logic                  regWrite,
  output fwdSelT                fwdSelA,
  output fwdSelT                fwdSelB
);

  // slot 1 is the nearest instruction ahead
  logic                  histWr [1:3];
  logic [REG_ADDR_W-1:0] histRd [1:3];
  logic                  newWr;

  // x0 writes and bubbles never forward
  assign newWr = accept && regWrite && (rd != '0);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      histWr[1] <= 1'b0;
      histWr[2] <= 1'b0;
      histWr[3] <= 1'b0;
    end else if (advance) begin
      histWr[1] <= newWr;
      histWr[2] <= histWr[1];
      histWr[3] <= histWr[2];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      histRd[1] <= rd;  // only meaningful behind a set flag
      histRd[2] <= histRd[1];
      histRd[3] <= histRd[2];
    end
  end

  function automatic fwdSelT nearest(input logic [REG_ADDR_W-1:0] src, input logic used);
    fwdSelT sel;
    sel = fwdNone;
    if (used) begin
      if (histWr[1] && (histRd[1] == src))      sel = fwdDist1;
      else if (histWr[2] && (histRd[2] == src)) sel = fwdDist2;
      else if (histWr[3] && (histRd[3] == src)) sel = fwdDist3;
    end
    return sel;
  endfunction

  always_comb begin
    fwdSelA = nearest(rs1, usesRs1);
    fwdSelB = nearest(rs2, usesRs2);
  end

endmodule

//--- idPipeReg.sv
`timescale 1ns/1ps

module idPipeReg import decodePkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  inValid,
  input  logic                  outReady,
  input  logic [XLEN-1:0]       pc,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic [XLEN-1:0]       imm,
  input  aluOpT                 aluOp,
  input  srcAT                  srcA,
  input  srcBT                  srcB,
  input  wbSelT                 wbSel,
  input  logic                  regWrite,
  input  logic                  memRead,
  input  logic                  memWrite,
  input  memSizeT               memSize,
  input  logic                  loadUnsigned,
  input  pcSelT                 pcSel,
  input  fwdSelT                fwdSelA,
  input  fwdSelT                fwdSelB,
  output logic                  inReady,
  output logic                  advance,
  output logic                  accept,
  output logic                  outValid,
  output logic [XLEN-1:0]       exPc,
  output logic [REG_ADDR_W-1:0] exRs1,
  output logic [REG_ADDR_W-1:0] exRs2,
  output logic [REG_ADDR_W-1:0] exRd,
  output logic [XLEN-1:0]       exImm,
  output aluOpT                 exAluOp,
  output srcAT                  exSrcA,
  output srcBT                  exSrcB,
  output wbSelT                 exWbSel,
  output logic                  exRegWrite,
  output logic                  exMemRead,
  output logic                  exMemWrite,
  output memSizeT               exMemSize,
  output logic                  exLoadUnsigned,
  output pcSelT                 exPcSel,
  output fwdSelT                exFwdSelA,
  output fwdSelT                exFwdSelB
);

  //--------------------------------------------------------------------------
  // handshake
  //--------------------------------------------------------------------------
  assign advance = !outValid || outReady;  // register empty or being drained
  assign inReady = advance && !flush;
  assign accept  = inValid && inReady;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      outValid <= 1'b0;
    end else if (advance) begin
      outValid <= accept;  // bubble when nothing came in
    end
  end

  //--------------------------------------------------------------------------
  // payload held while stalled
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      exPc           <= pc;
      exRs1          <= rs1;
      exRs2          <= rs2;
      exRd           <= rd;
      exImm          <= imm;
      exAluOp        <= aluOp;
      exSrcA         <= srcA;
      exSrcB         <= srcB;
      exWbSel        <= wbSel;
      exRegWrite     <= regWrite;
      exMemRead      <= memRead;
      exMemWrite     <= memWrite;
      exMemSize      <= memSize;
      exLoadUnsigned <= loadUnsigned;
      exPcSel        <= pcSel;
      exFwdSelA      <= fwdSelA;
      exFwdSelB      <= fwdSelB;
    end
  end

endmodule

//--- idStage.sv
`timescale 1ns/1ps

module idStage import decodePkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  inValid,
  input  logic [XLEN-1:0]       instr,
  input  logic [XLEN-1:0]       pc,
  input  logic                  outReady,
  output logic                  inReady,
  output logic                  outValid,
  output logic [XLEN-1:0]       outPc,
  output logic [REG_ADDR_W-1:0] rs1,
  output logic [REG_ADDR_W-1:0] rs2,
  output logic [REG_ADDR_W-1:0] rd,
  output logic [XLEN-1:0]       imm,
  output aluOpT                 aluOp,
  output srcAT                  srcA,
  output srcBT                  srcB,
  output wbSelT                 wbSel,
  output logic                  regWrite,
  output logic                  memRead,
  output logic                  memWrite,
  output memSizeT               memSize,
  output logic                  loadUnsigned,
  output pcSelT                 pcSel,
  output fwdSelT                fwdSelA,
  output fwdSelT                fwdSelB
);

  // decoded but not yet registered
  logic [REG_ADDR_W-1:0] decRs1;
  logic [REG_ADDR_W-1:0] decRs2;
  logic [REG_ADDR_W-1:0] decRd;
  logic [XLEN-1:0]       decImm;
  aluOpT                 decAluOp;
  srcAT                  decSrcA;
  srcBT                  decSrcB;
  wbSelT                 decWbSel;
  logic                  decRegWrite;
  logic                  decMemRead;
  logic                  decMemWrite;
  memSizeT               decMemSize;
  logic                  decLoadUnsigned;
  pcSelT                 decPcSel;
  logic                  decUsesRs1;
  logic                  decUsesRs2;
  fwdSelT                decFwdSelA;
  fwdSelT                decFwdSelB;
  logic                  advance;
  logic                  accept;

  assign decRs1 = instr[19:15];
  assign decRs2 = instr[24:20];
  assign decRd  = instr[11:7];

  immGen u_immGen (
    .instr (instr),
    .imm   (decImm)
  );

  ctrlDecode u_ctrlDecode (
    .instr        (instr),
    .aluOp        (decAluOp),
    .srcA         (decSrcA),
    .srcB         (decSrcB),
    .wbSel        (decWbSel),
    .regWrite     (decRegWrite),
    .memRead      (decMemRead),
    .memWrite     (decMemWrite),
    .memSize      (decMemSize),
    .loadUnsigned (decLoadUnsigned),
    .pcSel        (decPcSel),
    .usesRs1      (decUsesRs1),
    .usesRs2      (decUsesRs2)
  );

  fwdUnit u_fwdUnit (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .advance  (advance),
    .accept   (accept),
    .rs1      (decRs1),
    .rs2      (decRs2),
    .rd       (decRd),
    .usesRs1  (decUsesRs1),
    .usesRs2  (decUsesRs2),
    .regWrite (decRegWrite),
    .fwdSelA  (decFwdSelA),
    .fwdSelB  (decFwdSelB)
  );

  idPipeReg u_idPipeReg (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .inValid        (inValid),
    .outReady       (outReady),
    .pc             (pc),
    .rs1            (decRs1),
    .rs2            (decRs2),
    .rd             (decRd),
    .imm            (decImm),
    .aluOp          (decAluOp),
    .srcA           (decSrcA),
    .srcB           (decSrcB),
    .wbSel          (decWbSel),
    .regWrite       (decRegWrite),
    .memRead        (decMemRead),
    .memWrite       (decMemWrite),
    .memSize        (decMemSize),
    .loadUnsigned   (decLoadUnsigned),
    .pcSel          (decPcSel),
    .fwdSelA        (decFwdSelA),
    .fwdSelB        (decFwdSelB),
    .inReady        (inReady),
    .advance        (advance),
    .accept         (accept),
    .outValid       (outValid),
    .exPc           (outPc),
    .exRs1          (rs1),
    .exRs2          (rs2),
    .exRd           (rd),
    .exImm          (imm),
    .exAluOp        (aluOp),
    .exSrcA         (srcA),
    .exSrcB         (srcB),
    .exWbSel        (wbSel),
    .exRegWrite     (regWrite),
    .exMemRead      (memRead),
    .exMemWrite     (memWrite),
    .exMemSize      (memSize),
    .exLoadUnsigned (loadUnsigned),
    .exPcSel        (pcSel),
    .exFwdSelA      (fwdSelA),
    .exFwdSelB      (fwdSelB)
  );

endmodule

//--- immGen.sv
`timescale 1ns/1ps

module immGen import decodePkg::*; (
  input  logic [XLEN-1:0] instr,
  output logic [XLEN-1:0] imm
);

  opcodeT    opcode;
  logic      signBit;
  logic [XLEN-1:0] immI;
  logic [XLEN-1:0] immS;
  logic [XLEN-1:0] immB;
  logic [XLEN-1:0] immU;
  logic [XLEN-1:0] immJ;

  assign opcode  = opcodeT'(instr[6:0]);
  assign signBit = instr[31];  // every format takes its sign from bit 31

  // one candidate per format
  assign immI = {{(XLEN-12){signBit}}, instr[31:20]};
  assign immS = {{(XLEN-12){signBit}}, instr[31:25], instr[11:7]};
  assign immB = {{(XLEN-13){signBit}}, signBit, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{(XLEN-21){signBit}}, signBit, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (opcode)
      opOpImm,
      opLoad,
      opJalr:   imm = immI;
      opStore:  imm = immS;
      opBranch: imm = immB;
      opLui,
      opAuipc:  imm = immU;
      opJal:    imm = immJ;
      default:  imm = '0;  // OP and anything unknown
    endcase
  end

endmodule

//--- tbChecker.sv
`timescale 1ns/1ps

module tbChecker import decodePkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  inValid,
  input  logic [XLEN-1:0]       instr,
  input  logic [XLEN-1:0]       pc,
  input  logic                  inReady,
  input  logic                  outReady,
  input  logic                  outValid,
  input  logic [XLEN-1:0]       outPc,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic [XLEN-1:0]       imm,
  input  aluOpT                 aluOp,
  input  srcAT                  srcA,
  input  srcBT                  srcB,
  input  wbSelT                 wbSel,
  input  logic                  regWrite,
  input  logic                  memRead,
  input  logic                  memWrite,
  input  memSizeT               memSize,
  input  logic                  loadUnsigned,
  input  pcSelT                 pcSel,
  input  fwdSelT                fwdSelA,
  input  fwdSelT                fwdSelB,
  output int                    valueErrors,
  output int                    protocolErrors,
  output int                    transfers
);

  // expected outputs of one accepted instruction
  typedef struct packed {
    logic [1:0]            kind;  // 0 alu, 1 load/store, 2 branch/jump/upper, 3 no-op
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    aluOpT                 aluOp;
    srcAT                  srcA;
    srcBT                  srcB;
    wbSelT                 wbSel;
    logic                  regWrite;
    logic                  memRead;
    logic                  memWrite;
    memSizeT               memSize;
    logic                  loadUnsigned;
    pcSelT                 pcSel;
    fwdSelT                fwdA;
    fwdSelT                fwdB;
    logic                  usesRs1;
    logic                  usesRs2;
    logic [5:0]            care;  // alu, srcA, srcB, wb, size, unsigned
  } expT;

  expT                   expQ[$];
  logic                  expValid;
  logic                  histWr [1:3];
  logic [REG_ADDR_W-1:0] histRd [1:3];

  initial begin
    valueErrors    = 0;
    protocolErrors = 0;
    transfers      = 0;
  end

  //--------------------------------------------------------------------------
  // reference decode from the RV32I encodings
  //--------------------------------------------------------------------------
  function automatic expT modelDecode(input logic [31:0] w, input logic [31:0] pcVal);
    expT        e;
    logic [2:0] f3;
    f3 = w[14:12];
    e = '0;
    e.pc   = pcVal;
    e.rs1  = w[19:15];
    e.rs2  = w[24:20];
    e.rd   = w[11:7];
    e.kind = 2'd3;
    case (w[6:0])
      7'b0110011, 7'b0010011: begin  // OP, OP-IMM
        e.kind     = 2'd0;
        e.care     = 6'b111100;
        e.srcA     = srcARs1;
        e.srcB     = w[5] ? srcBRs2 : srcBImm;
        e.wbSel    = wbAlu;
        e.regWrite = 1'b1;
        e.usesRs1  = 1'b1;
        e.usesRs2  = w[5];
        if (!w[5]) e.imm = {{20{w[31]}}, w[31:20]};
        case (f3)
          3'd0: e.aluOp = (w[30] && w[5]) ? aluSub : aluAdd;
          3'd1: e.aluOp = aluSll;
          3'd2: e.aluOp = aluSlt;
          3'd3: e.aluOp = aluSltu;
          3'd4: e.aluOp = aluXor;
          3'd5: e.aluOp = w[30] ? aluSra : aluSrl;
          3'd6: e.aluOp = aluOr;
          default: e.aluOp = aluAnd;
        endcase
      end
      7'b0000011, 7'b0100011: begin  // LOAD, STORE
        e.kind     = 2'd1;
        e.aluOp    = aluAdd;
        e.srcA     = srcARs1;
        e.srcB     = srcBImm;
        e.usesRs1  = 1'b1;
        e.memRead  = !w[5];
        e.memWrite = w[5];
        e.regWrite = !w[5];
        e.usesRs2  = w[5];
        e.wbSel    = wbMem;
        e.imm      = w[5] ? {{20{w[31]}}, w[31:25], w[11:7]} : {{20{w[31]}}, w[31:20]};
        e.memSize  = (f3[1:0] == 2'd0) ? memByte : (f3[1:0] == 2'd1) ? memHalf : memWord;
        e.loadUnsigned = f3[2];
        if (w[5]) e.care = {3'b111, 1'b0, f3 < 3'd3, 1'b0};
        else      e.care = {4'b1111, {2{f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}}}};
      end
      7'b1100011: begin  // BRANCH
        e.kind    = 2'd2;
        e.pcSel   = pcBranch;
        e.srcA    = srcARs1;
        e.srcB    = srcBRs2;
        e.usesRs1 = 1'b1;
        e.usesRs2 = 1'b1;
        e.imm     = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        e.care    = {f3[2:1] != 2'b01, 5'b11000};
        case (f3)
          3'd0: e.aluOp = aluEq;
          3'd1: e.aluOp = aluNe;
          3'd4: e.aluOp = aluSlt;
          3'd5: e.aluOp = aluGe;
          3'd6: e.aluOp = aluSltu;
          default: e.aluOp = aluGeu;
        endcase
      end
      7'b1101111, 7'b1100111: begin  // JAL, JALR
        e.kind     = 2'd2;
        e.care     = 6'b111100;
        e.aluOp    = aluAdd;
        e.srcA     = srcAPc;
        e.srcB     = srcBFour;
        e.wbSel    = wbPcPlus4;
        e.regWrite = 1'b1;
        e.pcSel    = w[3] ? pcJal : pcJalr;
        e.usesRs1  = !w[3];
        if (w[3]) e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        else      e.imm = {{20{w[31]}}, w[31:20]};
      end
      7'b0110111, 7'b0010111: begin  // LUI, AUIPC
        e.kind     = 2'd2;
        e.care     = 6'b111100;
        e.aluOp    = aluAdd;
        e.srcA     = w[5] ? srcAZero : srcAPc;
        e.srcB     = srcBImm;
        e.wbSel    = wbAlu;
        e.regWrite = 1'b1;
        e.imm      = {w[31:12], 12'b0};
      end
      default: e.pcSel = pcSeq;  // no register, no memory, zero immediate
    endcase
    return e;
  endfunction

  function automatic fwdSelT nearestSlot(input logic [REG_ADDR_W-1:0] src, input logic used);
    for (int d = 1; d <= 3; d++) begin
      if (used && histWr[d] && histRd[d] == src) return fwdSelT'(d);
    end
    return fwdNone;
  endfunction

  function automatic string testName(input logic [1:0] kind);
    case (kind)
      2'd0: return "alu";
      2'd1: return "loadStore";
      2'd2: return "flowUpper";
      default: return "noOp";
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // comparison
  //--------------------------------------------------------------------------
  task automatic checkField(input string test, input string field,
                            input logic [31:0] expVal, input logic [31:0] actVal);
    if (actVal !== expVal) begin
      valueErrors++;
      $display("error %s %s at %0t: expected %0h actual %0h",
               test, field, $time, expVal, actVal);
    end
  endtask

  task automatic compareOutputs(input expT e);
    string name;
    name = testName(e.kind);
    checkField(name, "pc", e.pc, outPc);
    checkField(name, "rs1", e.rs1, rs1);
    checkField(name, "rs2", e.rs2, rs2);
    checkField(name, "rd", e.rd, rd);
    checkField(name, "imm", e.imm, imm);
    checkField(name, "regWrite", e.regWrite, regWrite);
    checkField(name, "memRead", e.memRead, memRead);
    checkField(name, "memWrite", e.memWrite, memWrite);
    checkField(name, "pcSel", e.pcSel, pcSel);
    if (e.care[5]) checkField(name, "aluOp", e.aluOp, aluOp);
    if (e.care[4]) checkField(name, "srcA", e.srcA, srcA);
    if (e.care[3]) checkField(name, "srcB", e.srcB, srcB);
    if (e.care[2]) checkField(name, "wbSel", e.wbSel, wbSel);
    if (e.care[1]) checkField(name, "memSize", e.memSize, memSize);
    if (e.care[0]) checkField(name, "loadUnsigned", e.loadUnsigned, loadUnsigned);
    checkField("forwarding", "fwdSelA", e.fwdA, fwdSelA);
    checkField("forwarding", "fwdSelB", e.fwdB, fwdSelB);
  endtask

  // inputs and outputs settle well before the falling edge, so the model
  // looks at what the next rising edge will do
  always @(negedge clk) begin : watch
    expT  e;
    logic advance;
    logic expInReady;
    logic accept;
    if (reset) begin
      expQ.delete();
      expValid = 1'b0;
      for (int s = 1; s <= 3; s++) histWr[s] = 1'b0;
    end else begin
      advance    = !expValid || outReady;
      expInReady = advance && !flush;
      if (outValid !== expValid) begin
        protocolErrors++;
        $display("error handshake outValid at %0t: expected %b actual %b",
                 $time, expValid, outValid);
      end
      if (inReady !== expInReady) begin
        protocolErrors++;
        $display("error handshake inReady at %0t: expected %b actual %b",
                 $time, expInReady, inReady);
      end
      if (expValid) begin
        compareOutputs(expQ[0]);  // also catches a change while stalled
        if (outReady || flush) begin
          e = expQ.pop_front();
          if (!flush) transfers++;  // a flushed instruction is dropped
        end
      end
      accept = inValid && expInReady;
      if (accept) begin
        e = modelDecode(instr, pc);
        e.fwdA = nearestSlot(e.rs1, e.usesRs1);
        e.fwdB = nearestSlot(e.rs2, e.usesRs2);
        expQ.push_back(e);
      end
      if (flush) begin
        expValid = 1'b0;
        for (int s = 1; s <= 3; s++) histWr[s] = 1'b0;
      end else if (advance) begin
        expValid  = accept;
        histWr[3] = histWr[2];
        histRd[3] = histRd[2];
        histWr[2] = histWr[1];
        histRd[2] = histRd[1];
        histWr[1] = accept && e.regWrite && (e.rd != '0);  // bubble otherwise
        histRd[1] = e.rd;
      end
    end
  end

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic reset
);

  localparam int halfPeriod = 4;  // 8 ns clock

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;  // released with the other stimulus
  end

  always #halfPeriod clk = ~clk;

endmodule

//--- tb_idStage.sv
`timescale 1ns/1ps

module tb_idStage import decodePkg::*; ();

  localparam int         numInstr   = 2000;
  localparam int         cycleLimit = 20 * numInstr + 100;
  localparam logic [6:0] opSystem   = 7'b1110011;
  localparam logic [6:0] opMiscMem  = 7'b0001111;

  logic                  clk;
  logic                  reset;
  logic                  flush;
  logic                  inValid;
  logic [XLEN-1:0]       instr;
  logic [XLEN-1:0]       pc;
  logic                  outReady;
  logic                  inReady;
  logic                  outValid;
  logic [XLEN-1:0]       outPc;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  aluOpT                 aluOp;
  srcAT                  srcA;
  srcBT                  srcB;
  wbSelT                 wbSel;
  logic                  regWrite;
  logic                  memRead;
  logic                  memWrite;
  memSizeT               memSize;
  logic                  loadUnsigned;
  pcSelT                 pcSel;
  fwdSelT                fwdSelA;
  fwdSelT                fwdSelB;
  int                    valueErrors;
  int                    protocolErrors;
  int                    transfers;
  int                    cycles = 0;
  int                    sent;
  logic                  took;
  int unsigned           seedDummy;

  tbClock u_clock (.clk(clk), .reset(reset));

  idStage i_idStage (
    .clk(clk), .reset(reset), .flush(flush), .inValid(inValid),
    .instr(instr), .pc(pc), .outReady(outReady), .inReady(inReady),
    .outValid(outValid), .outPc(outPc), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .aluOp(aluOp), .srcA(srcA), .srcB(srcB), .wbSel(wbSel), .regWrite(regWrite),
    .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
    .loadUnsigned(loadUnsigned), .pcSel(pcSel), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB)
  );

  tbChecker u_checker (
    .clk(clk), .reset(reset), .flush(flush), .inValid(inValid),
    .instr(instr), .pc(pc), .inReady(inReady), .outReady(outReady),
    .outValid(outValid), .outPc(outPc), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .aluOp(aluOp), .srcA(srcA), .srcB(srcB), .wbSel(wbSel), .regWrite(regWrite),
    .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
    .loadUnsigned(loadUnsigned), .pcSel(pcSel), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
    .valueErrors(valueErrors), .protocolErrors(protocolErrors), .transfers(transfers)
  );

  // registers limited to x0..x3 so that forwarding hits often
  function automatic logic [31:0] randInstr();
    logic [31:0] word;
    logic [6:0]  opc;
    word = $urandom;
    case ($urandom_range(10))
      0: opc = opLoad;
      1: opc = opStore;
      2: opc = opOp;
      3: opc = opOpImm;
      4: opc = opLui;
      5: opc = opAuipc;
      6: opc = opJal;
      7: opc = opJalr;
      8: opc = opBranch;
      9: opc = opSystem;
      default: opc = opMiscMem;
    endcase
    word[6:0]   = opc;
    word[11:7]  = $urandom_range(3);
    word[19:15] = $urandom_range(3);
    if (opc == opOp || opc == opStore || opc == opBranch) word[24:20] = $urandom_range(3);
    if (opc == opOp) word[31:25] = $urandom_range(1) ? 7'b0100000 : 7'b0000000;
    return word;
  endfunction

  initial begin
    seedDummy = $urandom(32'h28fe_e264);
    flush    = 1'b0;
    inValid  = 1'b0;
    outReady = 1'b0;
    instr    = '0;
    pc       = 32'h0000_1000;
    sent     = 0;
    @(negedge reset);
    while (sent < numInstr) begin
      @(negedge clk);
      took = inValid && inReady;
      if (took) sent++;
      @(posedge clk);
      #1;
      if (took || !inValid) begin  // fetch holds a word until it is taken
        inValid = ($urandom_range(99) < 80) && (sent < numInstr);
        if (inValid) begin
          instr = randInstr();
          pc    = pc + 4;
        end
      end
      outReady = $urandom_range(99) < 70;
      flush    = $urandom_range(99) == 0;
    end
    inValid  = 1'b0;
    flush    = 1'b0;
    outReady = 1'b1;
    do @(negedge clk); while (outValid);  // drain the last instruction
    @(posedge clk);
    $display("checked %0d transfers: %0d value errors, %0d protocol errors",
             transfers, valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0 && transfers > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ---------------------------------------------------------------------------
  // run limit
  // ---------------------------------------------------------------------------
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule
